// ==== verif/mul_stim.txt ====
# columns (hex): opcode target source tag opA opB expectedProduct gap randomGapFlag
# opcode 1 = multiply, 2 = response, 0 = unused; local tile is 05; gap in idle cycles
1 05 12 01 0003 0007 00000015 30 0   single multiply
2 09 12 02 1234 5678 00000000 0A 0   forward to another tile
1 05 21 10 0002 0003 00000006 00 0   burst start
1 05 21 11 00FF 0101 0000FFFF 00 0
1 05 22 12 1000 0010 00010000 00 0
1 05 22 13 ABCD 0001 0000ABCD 00 0
1 05 23 14 0100 0100 00010000 00 0
1 05 23 15 0007 0009 0000003F 00 0
1 05 24 16 8000 0002 00010000 00 0
1 05 24 17 0064 00C8 00004E20 30 0   burst end
2 0A 05 20 DEAD BEEF 00000000 00 0   interleaved forwards
1 05 31 21 0011 0011 00000121 00 0
1 07 05 22 CAFE F00D 00000000 01 0
1 05 31 23 0123 0045 00004E6F 00 0
2 0B 05 24 0000 0001 00000000 00 1
1 05 31 25 0000 FFFF 00000000 00 1   boundary operands
1 05 31 26 FFFF FFFF FFFE0001 00 1
1 05 31 27 FFFF 0000 00000000 10 0
0 05 31 28 1111 2222 00000000 10 0   dropped, unused opcode
2 05 31 29 3333 4444 00000000 08 0   dropped, response to us

// ==== src.f ====
+incdir+design
design/miniCorePkg.sv
design/transFifo.sv
design/accelDispatch.sv
design/mulLane.sv
design/rspMerge.sv
design/miniCoreAccelTop.sv
verif/miniCoreAccel_asserts.sv
verif/miniCoreAccelTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the tile accelerator testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module miniCoreAccelTb \
   -f src.f \
   -o simv
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/simv
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit "$status"
fi

exit 0

// ==== verif/miniCoreAccelTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "miniCore_settings.svh"

module miniCoreAccelTb
   import miniCorePkg::*;
();

   localparam tTileId thisTile       = 8'h05;   // localTileId of the DUT
   localparam int     arrivalTimeout = 600;     // cycles for outstanding outputs
   localparam int     drainCycles    = 40;      // quiet time for dropped tags
   localparam int     tagCount       = 1 << `TAG_W;

   logic      Clock;
   logic      arstN;
   tTileId    localTileId;
   logic      inFabricValid;
   tTileTrans inFabric;
   logic      outFabricValid;
   tTileTrans outFabric;

   // scoreboard keyed by tag
   tTileTrans   expTrans   [tagCount];
   logic [31:0] expProduct [tagCount];
   logic        expPending [tagCount];
   logic        expIsRsp   [tagCount];
   logic        dropTag    [tagCount];
   int          pendingCount;
   int          seed;

   miniCoreAccelTop u_dut (
      .Clock          (Clock),
      .arstN          (arstN),
      .localTileId    (localTileId),
      .inFabricValid  (inFabricValid),
      .inFabric       (inFabric),
      .outFabricValid (outFabricValid),
      .outFabric      (outFabric)
   );

   initial begin
      Clock = 1'b0;
      forever #10 Clock = ~Clock;               // 20 ns period
   end

   // ========================================
   // failure reporting and compares
   // ========================================
   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Test failures found");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkTrans(input tTileTrans expected, input tTileTrans actual);
      if (actual !== expected) begin
         $display("FAIL outFabric expected %h received %h", expected, actual);
         abortRun("fabric transaction mismatch");
      end
   endtask

   task automatic checkProduct(input logic [31:0] expected, input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAIL outFabric.data expected %h received %h", expected, actual);
         abortRun("product mismatch");
      end
   endtask

   // expected output derived from the decode rules
   task automatic expectFor(input tTileTrans sent, input logic [31:0] product);
      if (expPending[sent.tag] || dropTag[sent.tag])
         abortRun($sformatf("stimulus reuses tag %h", sent.tag));
      if (sent.target == thisTile && sent.opcode == OP_MUL) begin
         expTrans[sent.tag].opcode = OP_RSP;
         expTrans[sent.tag].target = sent.source;   // back to requestor
         expTrans[sent.tag].source = thisTile;
         expTrans[sent.tag].tag    = sent.tag;
         expTrans[sent.tag].data   = product;
         expProduct[sent.tag]      = product;
         expIsRsp[sent.tag]        = 1'b1;
         expPending[sent.tag]      = 1'b1;
         pendingCount++;
      end else if (sent.target != thisTile) begin
         expTrans[sent.tag]   = sent;               // forwarded unchanged
         expIsRsp[sent.tag]   = 1'b0;
         expPending[sent.tag] = 1'b1;
         pendingCount++;
      end else begin
         dropTag[sent.tag] = 1'b1;                  // other opcode to us
      end
   endtask

   task automatic handleOutput(input tTileTrans got);
      if (dropTag[got.tag]) begin
         abortRun($sformatf("dropped transaction with tag %h reached the output", got.tag));
      end else if (!expPending[got.tag]) begin
         abortRun($sformatf("unexpected or repeated output with tag %h", got.tag));
      end else begin
         if (expIsRsp[got.tag]) checkProduct(expProduct[got.tag], got.data);
         checkTrans(expTrans[got.tag], got);
         expPending[got.tag] = 1'b0;
         pendingCount--;
      end
   endtask

   // sample away from the driving edge
   always @(negedge Clock) begin
      if (arstN && outFabricValid) handleOutput(outFabric);
   end

   // ========================================
   // stimulus driving
   // ========================================
   task automatic sendTrans(input tTileTrans t);
      @(posedge Clock);
      #1;
      inFabricValid = 1'b1;                        // one-cycle strobe
      inFabric      = t;
   endtask

   task automatic idleCycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge Clock);
         #1;
         inFabricValid = 1'b0;
      end
   endtask

   initial begin
      int          fd;
      int          fields;
      int          gap;
      int          sent;
      int          waitCycles;
      string       line;
      logic [31:0] opV, tgtV, srcV, tagV, aV, bV, prodV, gapV, rndV;
      tTileTrans   t;

      seed          = 85;
      sent          = 0;
      pendingCount  = 0;
      localTileId   = thisTile;
      inFabricValid = 1'b0;
      inFabric      = '0;
      arstN         = 1'b1;
      for (int i = 0; i < tagCount; i++) begin
         expTrans[i]   = '0;
         expProduct[i] = '0;
         expPending[i] = 1'b0;
         expIsRsp[i]   = 1'b0;
         dropTag[i]    = 1'b0;
      end
      #1 arstN = 1'b0;                             // real falling edge for async reset
      repeat (8) @(posedge Clock);
      #1 arstN = 1'b1;
      idleCycles(2);

      fd = $fopen("verif/mul_stim.txt", "r");
      if (fd == 0) abortRun("cannot open stimulus file verif/mul_stim.txt");
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") continue;   // comment or blank
         fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                          opV, tgtV, srcV, tagV, aV, bV, prodV, gapV, rndV);
         if (fields != 9) abortRun($sformatf("malformed stimulus line: %s", line));
         t.opcode = tOpcode'(opV[1:0]);
         t.target = tgtV[`TILE_ID_W-1:0];
         t.source = srcV[`TILE_ID_W-1:0];
         t.tag    = tagV[`TAG_W-1:0];
         t.data   = {aV[15:0], bV[15:0]};          // opA high, opB low
         expectFor(t, prodV);
         sendTrans(t);
         sent++;
         if (rndV != 0) gap = $random(seed) & 7;
         else           gap = int'(gapV);
         idleCycles(gap);
      end
      $fclose(fd);
      idleCycles(1);
      if (sent == 0) abortRun("stimulus file held no transactions");

      waitCycles = 0;
      while (pendingCount != 0 && waitCycles < arrivalTimeout) begin
         @(posedge Clock);
         waitCycles++;
      end
      if (pendingCount != 0) begin
         for (int i = 0; i < tagCount; i++) begin
            if (expPending[i]) $display("tag %h never arrived at the fabric output", 8'(i));
         end
         abortRun("timed out waiting for outstanding transactions");
      end else begin
         repeat (drainCycles) @(posedge Clock);   // dropped tags must stay silent
         $display("All tests passed!");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== verif/miniCoreAccel_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "miniCore_settings.svh"

module miniCoreAccel_asserts (
   input logic                  Clock,
   input logic                  arstN,
   input logic                  mulPush,
   input logic                  mulFull,
   input logic                  fwdPush,
   input logic                  fwdFull,
   input logic [`MUL_LANES-1:0] laneStart,
   input logic [`MUL_LANES-1:0] laneIdle,
   input logic [`MUL_LANES-1:0] rspValid,
   input logic [`MUL_LANES-1:0] rspTaken,
   input logic                  outFabricValid
);

   // ========================================
   // queue overflow
   // ========================================
   mulQueueRoom: assert property (@(posedge Clock) disable iff (!arstN) mulPush |-> !mulFull)
      else $error("push to a full multiply queue");

   fwdQueueRoom: assert property (@(posedge Clock) disable iff (!arstN) fwdPush |-> !fwdFull)
      else $error("push to a full forward queue");

   // ========================================
   // lane handshakes
   // ========================================
   startOnIdle: assert property (@(posedge Clock) disable iff (!arstN)
      (laneStart & ~laneIdle) == '0)
      else $error("start issued to a busy lane");

   // a held result may only drop after it was taken
   rspHeld: assert property (@(posedge Clock) disable iff (!arstN)
      ($past(rspValid) & ~$past(rspTaken) & ~rspValid) == '0)
      else $error("lane result dropped before it was taken");

   quietInReset: assert property (@(posedge Clock) !arstN |-> !outFabricValid)
      else $error("fabric output strobe during reset");

endmodule

bind miniCoreAccelTop miniCoreAccel_asserts uAsserts (
   .Clock          (Clock),
   .arstN          (arstN),
   .mulPush        (uDispatch.mulPush),
   .mulFull        (uDispatch.uMulQueue.full),
   .fwdPush        (uDispatch.fwdPush),
   .fwdFull        (uDispatch.uFwdQueue.full),
   .laneStart      (laneStart),
   .laneIdle       (laneIdle),
   .rspValid       (laneRspValid),
   .rspTaken       (laneRspTaken),
   .outFabricValid (outFabricValid)
);

`default_nettype wire

// ==== design/miniCoreAccelTop.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "miniCore_settings.svh"

module miniCoreAccelTop
   import miniCorePkg::*;
(
   input  logic      Clock,
   input  logic      arstN,
   input  tTileId    localTileId,
   // ========================================
   // fabric side
   // ========================================
   input  logic      inFabricValid,
   input  tTileTrans inFabric,
   output logic      outFabricValid,
   output tTileTrans outFabric
);

   logic [`MUL_LANES-1:0] laneIdle;
   logic [`MUL_LANES-1:0] laneStart;
   tMulReq                laneReq;        // shared request bus
   logic [`MUL_LANES-1:0] laneRspValid;
   logic [`MUL_LANES-1:0] laneRspTaken;
   tMulRsp                laneRsp [`MUL_LANES];
   logic                  fwdValid;
   tTileTrans             fwd;
   logic                  fwdTaken;

   accelDispatch uDispatch (
      .Clock       (Clock),
      .arstN       (arstN),
      .localTileId (localTileId),
      .inValid     (inFabricValid),
      .inTrans     (inFabric),
      .laneIdle    (laneIdle),
      .fwdTaken    (fwdTaken),
      .laneStart   (laneStart),
      .laneReq     (laneReq),
      .fwdValid    (fwdValid),
      .fwd         (fwd)
   );

   for (genvar g = 0; g < `MUL_LANES; g++) begin : genLane
      mulLane uLane (
         .Clock    (Clock),
         .arstN    (arstN),
         .start    (laneStart[g]),
         .req      (laneReq),
         .rspTaken (laneRspTaken[g]),
         .idle     (laneIdle[g]),
         .rspValid (laneRspValid[g]),
         .rsp      (laneRsp[g])
      );
   end

   rspMerge uMerge (
      .Clock       (Clock),
      .arstN       (arstN),
      .localTileId (localTileId),
      .fwdValid    (fwdValid),
      .fwd         (fwd),
      .rspValid    (laneRspValid),
      .rsp         (laneRsp),
      .fwdTaken    (fwdTaken),
      .rspTaken    (laneRspTaken),
      .outValid    (outFabricValid),
      .outTrans    (outFabric)
   );

endmodule

`default_nettype wire

// ==== design/rspMerge.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "miniCore_settings.svh"

module rspMerge
   import miniCorePkg::*;
(
   input  logic                  Clock,
   input  logic                  arstN,
   input  tTileId                localTileId,
   input  logic                  fwdValid,
   input  tTileTrans             fwd,
   input  logic [`MUL_LANES-1:0] rspValid,
   input  tMulRsp                rsp [`MUL_LANES],
   output logic                  fwdTaken,
   output logic [`MUL_LANES-1:0] rspTaken,
   output logic                  outValid,
   output tTileTrans             outTrans
);

   logic [$clog2(`MUL_LANES)-1:0] rrPtr;     // last lane served
   logic [$clog2(`MUL_LANES)-1:0] pickIdx;
   logic                          rspFound;
   tTileTrans                     rspTrans;

   // ========================================
   // round-robin lane search
   // ========================================
   always_comb begin
      int idx;
      rspFound = 1'b0;
      pickIdx  = rrPtr;
      for (int i = 0; i < `MUL_LANES; i++) begin
         idx = (int'(rrPtr) + 1 + i) % `MUL_LANES;     // start after last served
         if (!rspFound && rspValid[idx]) begin
            rspFound = 1'b1;
            pickIdx  = ($clog2(`MUL_LANES))'(idx);
         end
      end
   end

   // forward has fixed priority
   always_comb begin
      fwdTaken = fwdValid;
      rspTaken = '0;
      if (!fwdValid && rspFound) rspTaken[pickIdx] = 1'b1;
   end

   // response formatting
   always_comb begin
      rspTrans.opcode = OP_RSP;
      rspTrans.target = rsp[pickIdx].requestor;   // back to requesting tile
      rspTrans.source = localTileId;
      rspTrans.tag    = rsp[pickIdx].tag;
      rspTrans.data   = rsp[pickIdx].product;
   end

   // ========================================
   // output register
   // ========================================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         outValid <= 1'b0;
         rrPtr    <= ($clog2(`MUL_LANES))'(`MUL_LANES - 1);  // first search from lane 0
      end else begin
         outValid <= fwdValid || rspFound;
         if (!fwdValid && rspFound) rrPtr <= pickIdx;
      end
   end

   always_ff @(posedge Clock) begin
      if (fwdValid)      outTrans <= fwd;           // unchanged pass-through
      else if (rspFound) outTrans <= rspTrans;
   end

endmodule

`default_nettype wire

// ==== design/mulLane.sv ====
`timescale 1ns/10ps
`default_nettype none

module mulLane
   import miniCorePkg::*;
(
   input  logic   Clock,
   input  logic   arstN,
   input  logic   start,
   input  tMulReq req,
   input  logic   rspTaken,
   output logic   idle,
   output logic   rspValid,
   output tMulRsp rsp
);

   typedef enum logic [1:0] {
      LANE_IDLE,
      LANE_RUN,
      LANE_HOLD
   } tLaneState;

   tLaneState   state;
   logic [3:0]  stepCnt;     // 16 shift-add steps
   logic [31:0] mcand;       // shifts left each step
   logic [15:0] mplier;      // shifts right, lsb selects add

   // ========================================
   // control FSM
   // ========================================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         state   <= LANE_IDLE;
         stepCnt <= '0;
      end else begin
         case (state)
            LANE_IDLE: if (start) begin
               state   <= LANE_RUN;
               stepCnt <= '0;
            end
            LANE_RUN: begin
               stepCnt <= stepCnt + 1'b1;
               if (stepCnt == 4'd15) state <= LANE_HOLD;   // last step done
            end
            LANE_HOLD: if (rspTaken) state <= LANE_IDLE;
            default:   state <= LANE_IDLE;
         endcase
      end
   end

   // ========================================
   // datapath
   // ========================================
   always_ff @(posedge Clock) begin
      if (state == LANE_IDLE && start) begin
         rsp.product   <= '0;
         rsp.requestor <= req.requestor;    // carried to response
         rsp.tag       <= req.tag;
         mcand         <= {16'b0, req.opA};
         mplier        <= req.opB;
      end else if (state == LANE_RUN) begin
         if (mplier[0]) rsp.product <= rsp.product + mcand;
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   assign idle     = (state == LANE_IDLE);
   assign rspValid = (state == LANE_HOLD);  // level until taken

endmodule

`default_nettype wire

// ==== design/accelDispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "miniCore_settings.svh"

module accelDispatch
   import miniCorePkg::*;
(
   input  logic                  Clock,
   input  logic                  arstN,
   input  tTileId                localTileId,
   input  logic                  inValid,
   input  tTileTrans             inTrans,
   input  logic [`MUL_LANES-1:0] laneIdle,
   input  logic                  fwdTaken,
   output logic [`MUL_LANES-1:0] laneStart,
   output tMulReq                laneReq,
   output logic                  fwdValid,
   output tTileTrans             fwd
);

   logic                  inValidQ;
   tTileTrans             inTransQ;
   logic                  isLocal;
   logic                  mulPush;
   logic                  fwdPush;
   tMulReq                mulReqIn;
   tMulReq                mulHead;
   logic                  mulNotEmpty;
   logic                  mulPop;
   logic [`MUL_LANES-1:0] availMask;
   logic [`MUL_LANES-1:0] pickOneHot;

   // ========================================
   // input stage and decode
   // ========================================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) inValidQ <= 1'b0;
      else        inValidQ <= inValid;
   end

   always_ff @(posedge Clock) begin
      inTransQ <= inTrans;                           // payload only
   end

   assign isLocal = (inTransQ.target == localTileId);
   assign mulPush = inValidQ && isLocal && (inTransQ.opcode == OP_MUL);
   assign fwdPush = inValidQ && !isLocal;            // other opcodes to us dropped

   assign mulReqIn.opA       = inTransQ.data[31:16];
   assign mulReqIn.opB       = inTransQ.data[15:0];
   assign mulReqIn.requestor = inTransQ.source;
   assign mulReqIn.tag       = inTransQ.tag;

   transFifo #(.tPayload(tMulReq)) uMulQueue (
      .Clock    (Clock),
      .arstN    (arstN),
      .push     (mulPush),
      .pushData (mulReqIn),
      .pop      (mulPop),
      .popData  (mulHead),
      .notEmpty (mulNotEmpty),
      .full     ()                                   // depth covers legal traffic
   );

   transFifo #(.tPayload(tTileTrans)) uFwdQueue (
      .Clock    (Clock),
      .arstN    (arstN),
      .push     (fwdPush),
      .pushData (inTransQ),
      .pop      (fwdTaken),                          // merger drains it
      .popData  (fwd),
      .notEmpty (fwdValid),
      .full     ()
   );

   // ========================================
   // lane issue
   // ========================================
   assign availMask = laneIdle & ~laneStart;         // lane issued last cycle still looks idle

   always_comb begin
      pickOneHot = '0;
      for (int i = `MUL_LANES - 1; i >= 0; i--) begin
         if (availMask[i]) begin
            pickOneHot    = '0;
            pickOneHot[i] = 1'b1;                    // lowest index wins
         end
      end
   end

   assign mulPop = mulNotEmpty && (|availMask);

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) laneStart <= '0;
      else        laneStart <= mulPop ? pickOneHot : '0;
   end

   always_ff @(posedge Clock) begin
      if (mulPop) laneReq <= mulHead;                // shared bus, start picks the lane
   end

endmodule

`default_nettype wire

// ==== design/transFifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "miniCore_settings.svh"

module transFifo #(
   parameter type tPayload = logic [31:0]
) (
   input  logic    Clock,
   input  logic    arstN,
   input  logic    push,
   input  tPayload pushData,
   input  logic    pop,
   output tPayload popData,
   output logic    notEmpty,
   output logic    full
);

   tPayload                            mem [`QUEUE_DEPTH];  // circular storage
   logic [$clog2(`QUEUE_DEPTH)-1:0]    wrPtr;
   logic [$clog2(`QUEUE_DEPTH)-1:0]    rdPtr;
   logic [$clog2(`QUEUE_DEPTH+1)-1:0]  count;               // entries held
   logic                               doPop;

   // wrap at depth, not only at a power of two
   function automatic logic [$clog2(`QUEUE_DEPTH)-1:0] nextPtr(
      input logic [$clog2(`QUEUE_DEPTH)-1:0] ptr
   );
      return (32'(ptr) == `QUEUE_DEPTH - 1) ? '0 : ptr + 1'b1;
   endfunction

   assign doPop = pop && notEmpty;                 // ignore pop when empty

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push)  wrPtr <= nextPtr(wrPtr);
         if (doPop) rdPtr <= nextPtr(rdPtr);
         case ({push, doPop})
            2'b10:   count <= count + 1'b1;       // push only
            2'b01:   count <= count - 1'b1;       // pop only
            default: count <= count;              // both or neither
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (push) mem[wrPtr] <= pushData;
   end

   assign popData  = mem[rdPtr];                   // head shown combinationally
   assign notEmpty = (count != '0);
   assign full     = (32'(count) == `QUEUE_DEPTH);

endmodule

`default_nettype wire

// ==== design/miniCorePkg.sv ====
`default_nettype none

`include "miniCore_settings.svh"

package miniCorePkg;

   // ========================================
   // fabric transaction
   // ========================================
   typedef enum logic [1:0] {
      OP_MUL = 2'b01,                // multiply request
      OP_RSP = 2'b10                 // product back to requestor
   } tOpcode;

   typedef logic [`TILE_ID_W-1:0] tTileId;

   typedef struct packed {
      tOpcode              opcode;
      tTileId              target;   // destination tile
      tTileId              source;   // originating tile
      logic [`TAG_W-1:0]   tag;      // echoed in the response
      logic [31:0]         data;     // {opA, opB} or product
   } tTileTrans;

   // ========================================
   // lane traffic
   // ========================================
   typedef struct packed {
      logic [15:0]         opA;      // multiplicand
      logic [15:0]         opB;      // multiplier
      tTileId              requestor;
      logic [`TAG_W-1:0]   tag;
   } tMulReq;

   typedef struct packed {
      logic [31:0]         product;
      tTileId              requestor; // becomes response target
      logic [`TAG_W-1:0]   tag;
   } tMulRsp;

endpackage

`default_nettype wire

// ==== design/miniCore_settings.svh ====
`ifndef MINICORE_SETTINGS_SVH
`define MINICORE_SETTINGS_SVH

// ========================================
// fabric field widths
// ========================================
`define TILE_ID_W   8   // mesh tile id bits
`define TAG_W       8   // request tag bits

// ========================================
// accelerator sizing
// ========================================
`define MUL_LANES   4   // iterative multiplier lanes
`define QUEUE_DEPTH 8   // entries per dispatch queue

`endif
